//--- silver_core_params.svh
// silver core parameters: word and register file sizes, instruction field positions
`ifndef SILVER_CORE_PARAMS_SVH
`define SILVER_CORE_PARAMS_SVH

`define WORD_W    32
`define REG_CNT   64
`define OUT_W     10

// instruction fields
`define RW_LSB    25 // destination
`define LC_BIT    24 // load constant class
`define A_IMM_BIT 23
`define RA_LSB    17
`define B_IMM_BIT 16
`define RB_LSB    10
`define FUNC_LSB  6

`define UPPER_W   9 // LoadUpperConstant field width

`endif

//--- silver_pkg.sv
// silver core types: register address, opcodes, alu functions and result source
`include "silver_core_params.svh"

package silver_pkg;

   typedef logic [$clog2(`REG_CNT)-1:0] reg_addr_t;

   // kept opcodes, everything else decodes as invalid
   typedef enum logic [5:0] {
      OPC_NORMAL     = 6'd0,
      OPC_SHIFT      = 6'd1,
      OPC_OUT        = 6'd6,
      OPC_LOAD_CONST = 6'd13,
      OPC_LOAD_UPPER = 6'd14,
      OPC_INVALID    = 6'd15
   } opc_t;

   typedef enum logic [3:0] {
      F_ADD,
      F_ADD_CARRY,
      F_SUB,
      F_CARRY,
      F_OVERFLOW,
      F_INC,
      F_DEC,
      F_MUL,
      F_MULHU,
      F_AND,
      F_OR,
      F_XOR,
      F_EQUAL,
      F_LESS,
      F_LOWER,
      F_SND
   } alu_func_t;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_SHIFT,
      WB_IMM // LoadConstant or merged LoadUpperConstant
   } wb_sel_t;

endpackage

//--- silver_decode.sv
// silver decode stage: instruction register, opcode classes, immediates and operands
`include "silver_core_params.svh"

module silver_decode (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`WORD_W-1:0]     instr,
   input  logic                   instr_valid,
   input  logic [`WORD_W-1:0]     rd_data_a,
   input  logic [`WORD_W-1:0]     rd_data_b,
   input  logic [`WORD_W-1:0]     rd_data_d,
   output silver_pkg::reg_addr_t  rd_addr_a,
   output silver_pkg::reg_addr_t  rd_addr_b,
   output silver_pkg::reg_addr_t  rd_addr_d,
   output silver_pkg::opc_t       dec_opc,
   output silver_pkg::alu_func_t  dec_func,
   output silver_pkg::reg_addr_t  dec_rw,
   output silver_pkg::reg_addr_t  dec_ra,
   output silver_pkg::reg_addr_t  dec_rb,
   output logic                   dec_a_imm,
   output logic                   dec_b_imm,
   output logic [`WORD_W-1:0]     dec_a,
   output logic [`WORD_W-1:0]     dec_b,
   output logic [`WORD_W-1:0]     dec_d,
   output logic [`WORD_W-1:0]     dec_imm
);

   localparam int AW = $bits(silver_pkg::reg_addr_t);
   localparam int FW = $bits(silver_pkg::alu_func_t);
   localparam logic [`WORD_W-1:0] INVALID_WORD = {{(`WORD_W-6){1'b0}}, 6'h3f};

   logic [`WORD_W-1:0] ir;
   logic [`WORD_W-1:0] lc_mag;

   function automatic logic [`WORD_W-1:0] sext_field(input logic [AW-1:0] v);
      return {{(`WORD_W-AW){v[AW-1]}}, v};
   endfunction

   always_ff @(posedge clk) begin
      if (rst)
         ir <= INVALID_WORD;
      else
         ir <= instr_valid ? instr : INVALID_WORD; // bubble when no word
   end

   always_comb begin
      if (ir[`LC_BIT]) begin
         if (ir[`WORD_W-1])
            dec_opc = silver_pkg::OPC_LOAD_CONST;
         else if (ir[`LC_BIT-1:`UPPER_W] == '0)
            dec_opc = silver_pkg::OPC_LOAD_UPPER;
         else
            dec_opc = silver_pkg::OPC_INVALID;
      end else if (ir[`WORD_W-1]) begin
         dec_opc = silver_pkg::OPC_INVALID;
      end else begin
         case (ir[5:0])
            6'd0:    dec_opc = silver_pkg::OPC_NORMAL;
            6'd1:    dec_opc = silver_pkg::OPC_SHIFT;
            6'd6:    dec_opc = silver_pkg::OPC_OUT;
            default: dec_opc = silver_pkg::OPC_INVALID; // memory, jumps, in, acc...
         endcase
      end
   end

   always_comb begin
      case (dec_opc)
         silver_pkg::OPC_NORMAL, silver_pkg::OPC_SHIFT, silver_pkg::OPC_OUT:
            dec_func = silver_pkg::alu_func_t'(ir[`FUNC_LSB +: FW]);
         default:
            dec_func = silver_pkg::F_AND;
      endcase
   end

   assign rd_addr_a = ir[`RA_LSB +: AW];
   assign rd_addr_b = ir[`RB_LSB +: AW];
   assign rd_addr_d = ir[`RW_LSB +: AW];

   assign dec_ra    = rd_addr_a;
   assign dec_rb    = rd_addr_b;
   assign dec_rw    = rd_addr_d;
   assign dec_a_imm = ir[`A_IMM_BIT];
   assign dec_b_imm = ir[`B_IMM_BIT];

   assign dec_a = dec_a_imm ? sext_field(rd_addr_a) : rd_data_a;
   assign dec_b = dec_b_imm ? sext_field(rd_addr_b) : rd_data_b;
   assign dec_d = rd_data_d; // old destination, for the upper merge

   // LoadConstant is sign and magnitude
   assign lc_mag = {{(`WORD_W-`LC_BIT+1){1'b0}}, ir[`LC_BIT-2:0]};

   always_comb begin
      case (dec_opc)
         silver_pkg::OPC_LOAD_CONST:
            dec_imm = ir[`LC_BIT-1] ? -lc_mag : lc_mag;
         silver_pkg::OPC_LOAD_UPPER:
            dec_imm = {{(`WORD_W-`UPPER_W){1'b0}}, ir[`UPPER_W-1:0]};
         default:
            dec_imm = '0;
      endcase
   end

   // a dropped sample always shows up as an invalid opcode one cycle later
   a_opc_kept: assert property (@(posedge clk) disable iff (rst)
      dec_opc inside {silver_pkg::OPC_NORMAL, silver_pkg::OPC_SHIFT, silver_pkg::OPC_OUT,
                      silver_pkg::OPC_LOAD_CONST, silver_pkg::OPC_LOAD_UPPER,
                      silver_pkg::OPC_INVALID}
      && ($past(instr_valid) || dec_opc == silver_pkg::OPC_INVALID));

endmodule

//--- silver_regfile.sv
// silver register file: 64 words, three combinational reads, one write with bypass
`include "silver_core_params.svh"

module silver_regfile (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [$clog2(`REG_CNT)-1:0]   rd_addr_a,
   input  logic [$clog2(`REG_CNT)-1:0]   rd_addr_b,
   input  logic [$clog2(`REG_CNT)-1:0]   rd_addr_d,
   input  logic                          wr_en,
   input  logic [$clog2(`REG_CNT)-1:0]   wr_addr,
   input  logic [`WORD_W-1:0]            wr_data,
   output logic [`WORD_W-1:0]            rd_data_a,
   output logic [`WORD_W-1:0]            rd_data_b,
   output logic [`WORD_W-1:0]            rd_data_d
);

   logic [`WORD_W-1:0] regs [`REG_CNT];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `REG_CNT; i++)
            regs[i] <= '0;
      end else if (wr_en) begin
         regs[wr_addr] <= wr_data; // always a full word
      end
   end

   // word being written wins over the stored one
   assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
   assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
   assign rd_data_d = (wr_en && wr_addr == rd_addr_d) ? wr_data : regs[rd_addr_d];

endmodule

//--- silver_alu.sv
// silver alu: sixteen functions with registered carry and overflow flags
`include "silver_core_params.svh"

module silver_alu (
   input  logic                   clk,
   input  logic                   rst,
   input  silver_pkg::alu_func_t  func,
   input  logic                   flag_en,
   input  logic [`WORD_W-1:0]     a,
   input  logic [`WORD_W-1:0]     b,
   output logic [`WORD_W-1:0]     result
);

   localparam int MSB = `WORD_W - 1;

   logic                 carry;
   logic                 overflow;
   logic                 carry_in;
   logic [`WORD_W:0]     sum;
   logic [`WORD_W-1:0]   diff;
   logic [2*`WORD_W-1:0] prod;
   logic                 add_ovf;
   logic                 sub_ovf;

   assign carry_in = (func == silver_pkg::F_ADD_CARRY) && carry;
   assign sum      = {1'b0, a} + {1'b0, b} + {{`WORD_W{1'b0}}, carry_in};
   assign diff     = a - b;
   assign prod     = {{`WORD_W{1'b0}}, a} * {{`WORD_W{1'b0}}, b};
   assign add_ovf  = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
   assign sub_ovf  = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

   always_ff @(posedge clk) begin
      if (rst) begin
         carry    <= 1'b0;
         overflow <= 1'b0;
      end else if (flag_en) begin
         case (func)
            silver_pkg::F_ADD: begin
               carry    <= sum[`WORD_W];
               overflow <= add_ovf;
            end
            silver_pkg::F_ADD_CARRY: carry    <= sum[`WORD_W];
            silver_pkg::F_SUB:       overflow <= sub_ovf;
            default: ; // other functions keep the flags
         endcase
      end
   end

   always_comb begin
      case (func)
         silver_pkg::F_ADD,
         silver_pkg::F_ADD_CARRY: result = sum[`WORD_W-1:0];
         silver_pkg::F_SUB:       result = diff;
         silver_pkg::F_CARRY:     result = {{(`WORD_W-1){1'b0}}, carry};
         silver_pkg::F_OVERFLOW:  result = {{(`WORD_W-1){1'b0}}, overflow};
         silver_pkg::F_INC:       result = a + 1'b1;
         silver_pkg::F_DEC:       result = a - 1'b1;
         silver_pkg::F_MUL:       result = prod[`WORD_W-1:0];
         silver_pkg::F_MULHU:     result = prod[2*`WORD_W-1:`WORD_W];
         silver_pkg::F_AND:       result = a & b;
         silver_pkg::F_OR:        result = a | b;
         silver_pkg::F_XOR:       result = a ^ b;
         silver_pkg::F_EQUAL:     result = {{(`WORD_W-1){1'b0}}, a == b};
         silver_pkg::F_LESS:      result = {{(`WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
         silver_pkg::F_LOWER:     result = {{(`WORD_W-1){1'b0}}, a < b};
         silver_pkg::F_SND:       result = b;
      endcase
   end

endmodule

//--- silver_execute.sv
// silver execute stage: operand forwarding, alu, shifter and result select
`include "silver_core_params.svh"

module silver_execute (
   input  logic                   clk,
   input  logic                   rst,
   input  silver_pkg::opc_t       dec_opc,
   input  silver_pkg::alu_func_t  dec_func,
   input  silver_pkg::reg_addr_t  dec_rw,
   input  silver_pkg::reg_addr_t  dec_ra,
   input  silver_pkg::reg_addr_t  dec_rb,
   input  logic                   dec_a_imm,
   input  logic                   dec_b_imm,
   input  logic [`WORD_W-1:0]     dec_a,
   input  logic [`WORD_W-1:0]     dec_b,
   input  logic [`WORD_W-1:0]     dec_d,
   input  logic [`WORD_W-1:0]     dec_imm,
   input  logic                   wr_en,
   input  silver_pkg::reg_addr_t  wr_addr,
   input  logic [`WORD_W-1:0]     wr_data,
   output logic                   ex_we,
   output silver_pkg::reg_addr_t  ex_rw,
   output logic [`WORD_W-1:0]     ex_result,
   output logic                   ex_is_out,
   output logic [`OUT_W-1:0]      ex_out_bits
);

   silver_pkg::opc_t      opc_q;
   silver_pkg::alu_func_t func_q;
   silver_pkg::reg_addr_t ra_q, rb_q;
   silver_pkg::wb_sel_t   wb_sel;
   logic                  a_imm_q, b_imm_q;
   logic [`WORD_W-1:0]    a_q, b_q, d_q, imm_q;
   logic                  fwd_a, fwd_b, fwd_d;
   logic [`WORD_W-1:0]    a_val, b_val, d_val;
   logic [`WORD_W-1:0]    alu_res, shift_res, load_val;
   logic [$clog2(`WORD_W)-1:0] rot;

   always_ff @(posedge clk) begin
      if (rst)
         opc_q <= silver_pkg::OPC_INVALID;
      else
         opc_q <= dec_opc;
   end

   always_ff @(posedge clk) begin
      func_q  <= dec_func;
      ex_rw   <= dec_rw;
      ra_q    <= dec_ra;
      rb_q    <= dec_rb;
      a_imm_q <= dec_a_imm;
      b_imm_q <= dec_b_imm;
      a_q     <= dec_a;
      b_q     <= dec_b;
      d_q     <= dec_d;
      imm_q   <= dec_imm;
   end

   // write-back result one stage ahead
   assign fwd_a = wr_en && wr_addr == ra_q && !a_imm_q;
   assign fwd_b = wr_en && wr_addr == rb_q && !b_imm_q;
   assign fwd_d = wr_en && wr_addr == ex_rw;
   assign a_val = fwd_a ? wr_data : a_q;
   assign b_val = fwd_b ? wr_data : b_q;
   assign d_val = fwd_d ? wr_data : d_q;

   silver_alu i_alu (
      .clk     (clk),
      .rst     (rst),
      .func    (func_q),
      .flag_en (opc_q == silver_pkg::OPC_NORMAL || opc_q == silver_pkg::OPC_OUT),
      .a       (a_val),
      .b       (b_val),
      .result  (alu_res)
   );

   assign rot = b_val[$clog2(`WORD_W)-1:0];

   always_comb begin
      case (func_q[1:0])
         2'd0:    shift_res = a_val << b_val;
         2'd1:    shift_res = a_val >> b_val;
         2'd2:    shift_res = $signed(a_val) >>> b_val;
         default: shift_res = (a_val >> rot) | (a_val << (`WORD_W - rot)); // ror
      endcase
   end

   // upper constant lands on top of the old destination value
   assign load_val = (opc_q == silver_pkg::OPC_LOAD_UPPER) ?
                     {imm_q[`UPPER_W-1:0], d_val[`WORD_W-`UPPER_W-1:0]} : imm_q;

   always_comb begin
      case (opc_q)
         silver_pkg::OPC_SHIFT:      wb_sel = silver_pkg::WB_SHIFT;
         silver_pkg::OPC_LOAD_CONST,
         silver_pkg::OPC_LOAD_UPPER: wb_sel = silver_pkg::WB_IMM;
         default:                    wb_sel = silver_pkg::WB_ALU;
      endcase
      case (wb_sel)
         silver_pkg::WB_SHIFT: ex_result = shift_res;
         silver_pkg::WB_IMM:   ex_result = load_val;
         default:              ex_result = alu_res;
      endcase
   end

   assign ex_we = opc_q inside {silver_pkg::OPC_NORMAL, silver_pkg::OPC_SHIFT,
                                silver_pkg::OPC_OUT, silver_pkg::OPC_LOAD_CONST,
                                silver_pkg::OPC_LOAD_UPPER};
   assign ex_is_out   = opc_q == silver_pkg::OPC_OUT;
   assign ex_out_bits = ex_result[`OUT_W-1:0];

   // forwarded value belongs to the instruction that sat here one cycle before
   a_fwd_a: assert property (@(posedge clk) disable iff (rst)
      fwd_a |-> !a_imm_q && $past(ex_we) && $past(ex_rw) == ra_q);
   a_fwd_b: assert property (@(posedge clk) disable iff (rst)
      fwd_b |-> !b_imm_q && $past(ex_we) && $past(ex_rw) == rb_q);

endmodule

//--- silver_writeback.sv
// silver write-back stage: register file write and the data_out level
`include "silver_core_params.svh"

module silver_writeback (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   ex_we,
   input  silver_pkg::reg_addr_t  ex_rw,
   input  logic [`WORD_W-1:0]     ex_result,
   input  logic                   ex_is_out,
   input  logic [`OUT_W-1:0]      ex_out_bits,
   output logic                   wr_en,
   output silver_pkg::reg_addr_t  wr_addr,
   output logic [`WORD_W-1:0]     wr_data,
   output logic [`OUT_W-1:0]      data_out
);

   logic              out_q;
   logic [`OUT_W-1:0] out_bits_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_en <= 1'b0;
         out_q <= 1'b0;
      end else begin
         wr_en <= ex_we;
         out_q <= ex_is_out;
      end
   end

   always_ff @(posedge clk) begin
      wr_addr    <= ex_rw;
      wr_data    <= ex_result;
      out_bits_q <= ex_out_bits;
   end

   // level follows the register write by one edge
   always_ff @(posedge clk) begin
      if (rst)
         data_out <= '0;
      else if (out_q)
         data_out <= out_bits_q;
   end

   // new level is the low part of the word the out wrote
   a_out_only: assert property (@(posedge clk) disable iff (rst)
      !$stable(data_out) |-> $past(out_q) && data_out == $past(wr_data[`OUT_W-1:0]));

endmodule

//--- silver_core.sv
// silver core top: four-stage in-order pipeline around a shared register file
`include "silver_core_params.svh"

module silver_core (
   input  logic                clk,
   input  logic                rst,
   input  logic [`WORD_W-1:0]  instr,
   input  logic                instr_valid,
   output logic [`OUT_W-1:0]   data_out
);

   silver_pkg::reg_addr_t rd_addr_a, rd_addr_b, rd_addr_d;
   logic [`WORD_W-1:0]    rd_data_a, rd_data_b, rd_data_d;

   silver_pkg::opc_t      dec_opc;
   silver_pkg::alu_func_t dec_func;
   silver_pkg::reg_addr_t dec_rw, dec_ra, dec_rb;
   logic                  dec_a_imm, dec_b_imm;
   logic [`WORD_W-1:0]    dec_a, dec_b, dec_d, dec_imm;

   logic                  ex_we, ex_is_out;
   silver_pkg::reg_addr_t ex_rw;
   logic [`WORD_W-1:0]    ex_result;
   logic [`OUT_W-1:0]     ex_out_bits;

   logic                  wr_en;
   silver_pkg::reg_addr_t wr_addr;
   logic [`WORD_W-1:0]    wr_data;

   silver_decode i_decode (
      .clk, .rst, .instr, .instr_valid,
      .rd_data_a, .rd_data_b, .rd_data_d,
      .rd_addr_a, .rd_addr_b, .rd_addr_d,
      .dec_opc, .dec_func, .dec_rw, .dec_ra, .dec_rb,
      .dec_a_imm, .dec_b_imm, .dec_a, .dec_b, .dec_d, .dec_imm
   );

   silver_regfile i_regfile (
      .clk, .rst,
      .rd_addr_a, .rd_addr_b, .rd_addr_d,
      .wr_en, .wr_addr, .wr_data,
      .rd_data_a, .rd_data_b, .rd_data_d
   );

   silver_execute i_execute (
      .clk, .rst,
      .dec_opc, .dec_func, .dec_rw, .dec_ra, .dec_rb,
      .dec_a_imm, .dec_b_imm, .dec_a, .dec_b, .dec_d, .dec_imm,
      .wr_en, .wr_addr, .wr_data,
      .ex_we, .ex_rw, .ex_result, .ex_is_out, .ex_out_bits
   );

   silver_writeback i_writeback (
      .clk, .rst,
      .ex_we, .ex_rw, .ex_result, .ex_is_out, .ex_out_bits,
      .wr_en, .wr_addr, .wr_data, .data_out
   );

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset source: free-running clock, reset held for the first cycles
module tb_clock_gen #(
   parameter int PERIOD     = 100,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0; // released on the edge, like any other input
   end

endmodule

//--- silver_core_tb.sv
// silver core testbench: instruction table applied in order, data_out checked per row
`include "silver_core_params.svh"

module silver_core_tb;

   localparam logic [3:0] SH_LL  = 4'd0;
   localparam logic [3:0] SH_LR  = 4'd1;
   localparam logic [3:0] SH_AR  = 4'd2;
   localparam logic [3:0] SH_ROR = 4'd3;
   localparam logic [`WORD_W-1:0] NOP_WORD = 32'h0000_0002; // dropped memory opcode

   logic               clk;
   logic               rst;
   logic [`WORD_W-1:0] instr;
   logic               instr_valid;
   logic [`OUT_W-1:0]  data_out;

   string              name_q [$];
   logic [`WORD_W-1:0] word_q [$];
   bit                 chk_q  [$];
   logic [`OUT_W-1:0]  exp_q  [$];

   integer seed;
   int     row_cnt     = 0;
   int     n_checked   = 0;
   int     checks_done = 0;
   int     pass_cnt    = 0;
   int     err_cnt     = 0;
   int     cycles      = 0;
   int     cycle_limit = 0;
   int     cur_row     = -1; // row the DUT samples at the next edge
   int     pipe [4]    = '{-1, -1, -1, -1};

   tb_clock_gen #(.PERIOD(100), .RST_CYCLES(3)) i_clock_gen (.clk(clk), .rst(rst));

   silver_core i_silver_core (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .instr_valid (instr_valid),
      .data_out    (data_out)
   );

   function automatic logic [`WORD_W-1:0] alu_word(input logic [5:0] opc, input int rw,
         input bit a_imm, input int ra, input bit b_imm, input int rb, input logic [3:0] func);
      logic [`WORD_W-1:0] w;
      w = '0;
      w[`RW_LSB +: 6]   = rw[5:0];
      w[`A_IMM_BIT]     = a_imm;
      w[`RA_LSB +: 6]   = ra[5:0];
      w[`B_IMM_BIT]     = b_imm;
      w[`RB_LSB +: 6]   = rb[5:0];
      w[`FUNC_LSB +: 4] = func;
      w[5:0]            = opc;
      return w;
   endfunction

   function automatic logic [`WORD_W-1:0] reg_op(input logic [3:0] func, input int rw,
         input int ra, input int rb);
      return alu_word(silver_pkg::OPC_NORMAL, rw, 1'b0, ra, 1'b0, rb, func);
   endfunction

   function automatic logic [`WORD_W-1:0] shift_op(input logic [3:0] kind, input int rw,
         input int ra, input int amount);
      return alu_word(silver_pkg::OPC_SHIFT, rw, 1'b0, ra, 1'b1, amount, kind);
   endfunction

   // out always lands in r63, never read back
   function automatic logic [`WORD_W-1:0] out_op(input logic [3:0] func, input bit a_imm,
         input int ra, input bit b_imm, input int rb);
      return alu_word(silver_pkg::OPC_OUT, 63, a_imm, ra, b_imm, rb, func);
   endfunction

   function automatic logic [`WORD_W-1:0] show_reg(input int rb);
      return out_op(silver_pkg::F_SND, 1'b0, 0, 1'b0, rb);
   endfunction

   function automatic logic [`WORD_W-1:0] const_op(input int rw, input int value);
      logic [`WORD_W-1:0] w;
      int                 mag;
      mag = (value < 0) ? -value : value;
      w = '0;
      w[`WORD_W-1]     = 1'b1;
      w[`RW_LSB +: 6]  = rw[5:0];
      w[`LC_BIT]       = 1'b1;
      w[`LC_BIT-1]     = value < 0; // sign and magnitude
      w[`LC_BIT-2:0]   = mag[`LC_BIT-2:0];
      return w;
   endfunction

   function automatic logic [`WORD_W-1:0] upper_op(input int rw, input logic [8:0] v);
      logic [`WORD_W-1:0] w;
      w = '0;
      w[`RW_LSB +: 6] = rw[5:0];
      w[`LC_BIT]      = 1'b1;
      w[8:0]          = v;
      return w;
   endfunction

   task automatic add_row(input string name, input logic [`WORD_W-1:0] w, input bit chk,
         input logic [`OUT_W-1:0] exp_v);
      name_q.push_back(name);
      word_q.push_back(w);
      chk_q.push_back(chk);
      exp_q.push_back(exp_v);
      if (chk)
         n_checked++;
   endtask

   task automatic add_step(input logic [`WORD_W-1:0] w);
      add_row("", w, 1'b0, '0);
   endtask

   task automatic add_check(input string name, input logic [`WORD_W-1:0] w,
         input logic [`OUT_W-1:0] exp_v);
      add_row(name, w, 1'b1, exp_v);
   endtask

   task automatic build_table();
      add_check("reset_add", out_op(silver_pkg::F_ADD, 1'b0, 5, 1'b0, 6), 10'h000);
      add_step(const_op(1, 1000));
      add_check("lc_pos", show_reg(1), 10'h3e8);
      add_step(const_op(2, -5));
      add_check("lc_neg", show_reg(2), 10'h3fb);
      add_step(const_op(3, 32'h12345));
      add_check("lc_wide", show_reg(3), 10'h345);
      add_check("imm_snd", out_op(silver_pkg::F_SND, 1'b0, 0, 1'b1, -3), 10'h3fd);
      add_check("imm_add", out_op(silver_pkg::F_ADD, 1'b1, 20, 1'b1, -16), 10'h004);
      // dropped encodings aimed at r1
      add_step(alu_word(6'd2, 1, 1'b0, 0, 1'b0, 0, silver_pkg::F_ADD));
      add_step(upper_op(1, 9'h000) | 32'h00ff_fe00);
      add_step(32'h8000_0000 | reg_op(silver_pkg::F_ADD, 1, 0, 0));
      add_check("dropped_ops", show_reg(1), 10'h3e8);
      // distance 1 chain
      add_step(const_op(10, 7));
      add_step(const_op(11, 100));
      add_step(reg_op(silver_pkg::F_ADD, 12, 10, 11));
      add_step(reg_op(silver_pkg::F_SUB, 13, 12, 10));
      add_step(reg_op(silver_pkg::F_XOR, 14, 13, 12));
      add_check("chain_d1", show_reg(14), 10'h00f);
      // distance 2
      add_step(const_op(15, 3000));
      add_step(NOP_WORD);
      add_step(reg_op(silver_pkg::F_MUL, 16, 15, 15));
      add_step(NOP_WORD);
      add_check("chain_d2", show_reg(16), 10'h040);
      // distance 3
      add_step(const_op(17, 32'h7fffff));
      add_step(NOP_WORD);
      add_step(NOP_WORD);
      add_step(reg_op(silver_pkg::F_MULHU, 18, 17, 2));
      add_step(NOP_WORD);
      add_step(NOP_WORD);
      add_check("chain_d3", show_reg(18), 10'h3fe);
      add_step(reg_op(silver_pkg::F_LESS, 19, 2, 10));
      add_step(reg_op(silver_pkg::F_LOWER, 20, 2, 19));
      add_step(reg_op(silver_pkg::F_LOWER, 21, 20, 19));
      add_check("less_lower", out_op(silver_pkg::F_SUB, 1'b0, 21, 1'b0, 20), 10'h001);
      // shifts
      add_step(shift_op(SH_LL, 31, 1, 4));
      add_check("shift_ll", show_reg(31), 10'h280);
      add_step(shift_op(SH_LR, 32, 1, 3));
      add_check("shift_lr", show_reg(32), 10'h07d);
      add_step(shift_op(SH_AR, 33, 2, 24));
      add_check("shift_ar", show_reg(33), 10'h3ff);
      add_step(shift_op(SH_ROR, 34, 1, 0));
      add_check("ror_0", show_reg(34), 10'h3e8);
      add_step(shift_op(SH_ROR, 35, 2, 31));
      add_check("ror_31", show_reg(35), 10'h3f7);
      // upper constant over a loaded word
      add_step(const_op(40, 32'h12345));
      add_step(upper_op(40, 9'h1a5));
      add_step(const_op(41, 512));
      add_check("lui_upper", out_op(silver_pkg::F_MULHU, 1'b0, 40, 1'b0, 41), 10'h1a5);
      add_check("lui_lower", show_reg(40), 10'h345);
      // flags
      add_step(const_op(50, -1));
      add_step(const_op(51, 1));
      add_step(reg_op(silver_pkg::F_ADD, 52, 50, 51));
      add_check("carry_set", out_op(silver_pkg::F_CARRY, 1'b0, 0, 1'b0, 0), 10'h001);
      add_step(const_op(53, 32'h7fffff));
      add_step(upper_op(53, 9'h0ff)); // largest positive word
      add_step(reg_op(silver_pkg::F_SUB, 54, 53, 50));
      add_check("overflow_set", out_op(silver_pkg::F_OVERFLOW, 1'b0, 0, 1'b0, 0), 10'h001);
      add_step(reg_op(silver_pkg::F_ADD_CARRY, 55, 51, 51));
      add_check("addc_carry_in", show_reg(55), 10'h003);
      add_check("carry_clear", out_op(silver_pkg::F_CARRY, 1'b0, 0, 1'b0, 0), 10'h000);
      add_step(reg_op(silver_pkg::F_ADD_CARRY, 56, 51, 51));
      add_check("addc_no_carry", show_reg(56), 10'h002);
   endtask

   task automatic check_value(input string name, input logic [`OUT_W-1:0] exp_v,
         input logic [`OUT_W-1:0] act_v);
      assert (act_v === exp_v) begin
         pass_cnt++;
         $display("ok %s data_out %h", name, act_v);
      end else begin
         err_cnt++;
         $display("Error %s expected %h actual %h", name, exp_v, act_v);
      end
   endtask

   // row sampled at edge k shows on data_out after edge k+3
   always @(posedge clk) begin
      pipe[0] <= cur_row;
      pipe[1] <= pipe[0];
      pipe[2] <= pipe[1];
      pipe[3] <= pipe[2];
   end

   always @(negedge clk) begin
      if (pipe[3] >= 0 && chk_q[pipe[3]]) begin
         check_value(name_q[pipe[3]], exp_q[pipe[3]], data_out);
         checks_done++;
      end
   end

   initial begin
      seed = 32'ha99c;
      instr       <= '0;
      instr_valid <= 1'b0;
      build_table();
      row_cnt = word_q.size();
      @(negedge clk);
      while (rst)
         @(negedge clk);
      check_value("after_reset", '0, data_out);
      for (int r = 0; r < row_cnt; r++) begin
         @(posedge clk);
         instr       <= word_q[r];
         instr_valid <= 1'b1;
         cur_row     <= r;
         if (chk_q[r] && ($random(seed) & 1)) begin
            @(posedge clk);
            instr_valid <= 1'b0; // bubble
            cur_row     <= -1;
         end
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      cur_row     <= -1;
      while (checks_done < n_checked)
         @(negedge clk);
      $display("summary: %0d passed, %0d failed", pass_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   initial begin
      @(posedge clk);
      cycle_limit = 2 * row_cnt + 20;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- silver_core.f
+incdir+.
silver_pkg.sv
silver_decode.sv
silver_regfile.sv
silver_alu.sv
silver_execute.sv
silver_writeback.sv
silver_core.sv
tb_clock_gen.sv
silver_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the silver core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f silver_core.f --top-module silver_core_tb -o silver_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/silver_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1
